// ==== logic/dl11_cfg.svh ====
// ----------------------------------------
// DL11 console line configuration
// register offsets, vectors, baud divisors
// ----------------------------------------
`ifndef DL11_CFG_SVH
`define DL11_CFG_SVH

// I/O page offsets of the four registers
`define DL11_RCSR_ADDR 13'o17560
`define DL11_RBUF_ADDR 13'o17562
`define DL11_XCSR_ADDR 13'o17564
`define DL11_XBUF_ADDR 13'o17566

// interrupt vectors, receive wins over transmit
`define DL11_RX_VECTOR 8'o60
`define DL11_TX_VECTOR 8'o64

// clk cycles per 16x sample tick, one bit is 64 clk
`define DL11_TICK_DIV 4

// sample ticks per serial bit
`define DL11_OVERSAMPLE 16

// CSR bit positions
`define DL11_CSR_DONE_BIT 7
`define DL11_CSR_IE_BIT 6

`endif

// ==== logic/iopage_pkg.sv ====
// ----------------------------------------
// I/O page bus types and register select
// ----------------------------------------
`default_nettype none

package iopage_pkg;

   // 13-bit offset within the I/O page
   typedef logic [12:0] iopage_addr_t;

   // word-wide data path
   typedef logic [15:0] iopage_data_t;

   // decoded DL11 register
   typedef enum logic [2:0]
   {
      RCSR,
      RBUF,
      XCSR,
      XBUF,
      NONE
   } dl11_reg_e;

endpackage

`default_nettype wire

// ==== logic/serial_pkg.sv ====
// ----------------------------------------
// serial character type and FSM states
// ----------------------------------------
`default_nettype none

package serial_pkg;

   typedef logic [7:0] char_t;

   // serializer and deserializer frame states
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   // register side handshake with the transmitter
   typedef enum logic [1:0] {READY, LOAD, BUSY} xmit_hs_e;

   // register side handshake with the receiver
   typedef enum logic [1:0] {WAIT, UNLOAD, DONE} recv_hs_e;

endpackage

`default_nettype wire

// ==== logic/dl11_regs.sv ====
// ----------------------------------------
// DL11 register block
// CSR/buffer registers, handshakes, interrupt
// ----------------------------------------
`default_nettype none

`include "dl11_cfg.svh"

module dl11_regs
(
   input  wire                      clk,
   input  wire                      reset,
   input  iopage_pkg::iopage_addr_t iopage_addr,
   input  iopage_pkg::iopage_data_t data_in,
   input  wire                      iopage_rd,
   input  wire                      iopage_wr,
   output iopage_pkg::iopage_data_t data_out,
   output logic                     decode,
   output logic                     interrupt,
   output logic [7:0]               vector,
   output logic                     ld_tx_data,
   output serial_pkg::char_t        tx_data,
   output logic                     uld_rx_data,
   input  wire                      tx_empty,
   input  wire                      rx_empty,
   input  serial_pkg::char_t        rx_data
);

   iopage_pkg::dl11_reg_e reg_sel;
   serial_pkg::xmit_hs_e  xmit_state;
   serial_pkg::recv_hs_e  recv_state;
   serial_pkg::char_t     xbuf;
   serial_pkg::char_t     rbuf;
   logic                  rx_ie;
   logic                  tx_ie;
   logic                  rx_done;
   logic                  tx_done;
   logic                  rx_cause;
   logic                  tx_cause;
   logic                  xbuf_wr;
   logic                  rbuf_rd;

   // address decode, independent of rd/wr
   always_comb
   begin
      case (iopage_addr)
         `DL11_RCSR_ADDR: reg_sel = iopage_pkg::RCSR;
         `DL11_RBUF_ADDR: reg_sel = iopage_pkg::RBUF;
         `DL11_XCSR_ADDR: reg_sel = iopage_pkg::XCSR;
         `DL11_XBUF_ADDR: reg_sel = iopage_pkg::XBUF;
         default:         reg_sel = iopage_pkg::NONE;
      endcase
   end

   assign decode = (reg_sel != iopage_pkg::NONE);

   // read mux
   always_comb
   begin
      data_out = '0;
      if (iopage_rd)
      begin
         case (reg_sel)
            iopage_pkg::RCSR:
            begin
               data_out[`DL11_CSR_DONE_BIT] = rx_done;
               data_out[`DL11_CSR_IE_BIT]   = rx_ie;
            end
            iopage_pkg::RBUF: data_out = {8'h00, rbuf};
            iopage_pkg::XCSR:
            begin
               data_out[`DL11_CSR_DONE_BIT] = tx_done;
               data_out[`DL11_CSR_IE_BIT]   = tx_ie;
            end
            iopage_pkg::XBUF: data_out = {8'h00, xbuf};
            default: data_out = '0;
         endcase
      end
   end

   // register writes, byte lanes are not distinguished
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_ie <= 1'b0;
         tx_ie <= 1'b0;
         xbuf  <= '0;
      end
      else if (iopage_wr)
      begin
         case (reg_sel)
            iopage_pkg::RCSR: rx_ie <= data_in[`DL11_CSR_IE_BIT];
            iopage_pkg::XCSR: tx_ie <= data_in[`DL11_CSR_IE_BIT];
            iopage_pkg::XBUF: xbuf  <= data_in[7:0];
            default: ;
         endcase
      end
   end

   assign xbuf_wr = iopage_wr && (reg_sel == iopage_pkg::XBUF);
   assign rbuf_rd = iopage_rd && (reg_sel == iopage_pkg::RBUF);

   // transmit handshake
   // hold the load strobe until the transmitter leaves empty,
   // then wait for the whole frame before reporting done
   always_ff @(posedge clk)
   begin
      if (reset)
         xmit_state <= serial_pkg::READY;
      else
      begin
         case (xmit_state)
            serial_pkg::READY: if (xbuf_wr) xmit_state <= serial_pkg::LOAD;
            serial_pkg::LOAD:  if (!tx_empty) xmit_state <= serial_pkg::BUSY;
            serial_pkg::BUSY:  if (tx_empty) xmit_state <= serial_pkg::READY;
            default:           xmit_state <= serial_pkg::READY;
         endcase
      end
   end

   // receive handshake
   // one unload strobe frees the receiver, the receiver answers next cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         recv_state <= serial_pkg::WAIT;
      else
      begin
         case (recv_state)
            serial_pkg::WAIT:   if (!rx_empty) recv_state <= serial_pkg::UNLOAD;
            serial_pkg::UNLOAD: recv_state <= serial_pkg::DONE;
            serial_pkg::DONE:   if (rbuf_rd) recv_state <= serial_pkg::WAIT;
            default:            recv_state <= serial_pkg::WAIT;
         endcase
      end
   end

   // received character, overwritten by any newer one
   always_ff @(posedge clk)
   begin
      if (!rx_empty)
         rbuf <= rx_data;
   end

   assign ld_tx_data  = (xmit_state == serial_pkg::LOAD);
   assign uld_rx_data = (recv_state == serial_pkg::UNLOAD);
   assign tx_data     = xbuf;
   assign tx_done     = (xmit_state == serial_pkg::READY);
   assign rx_done     = (recv_state == serial_pkg::DONE);

   // interrupt follows its cause, no acknowledge
   assign rx_cause = rx_ie && rx_done;
   assign tx_cause = tx_ie && tx_done;

   always_ff @(posedge clk)
   begin
      if (reset)
         interrupt <= 1'b0;
      else
         interrupt <= rx_cause || tx_cause;
   end

   assign vector = rx_cause ? `DL11_RX_VECTOR :
                   tx_cause ? `DL11_TX_VECTOR :
                   8'h00;

   // both strobes are quiet right after a reset cycle
   a_strobes_reset: assert property (@(posedge clk)
      reset |=> !ld_tx_data && !uld_rx_data)
      else $error("dl11_regs: strobe active after reset");

   // a cause held over two cycles shows as interrupt with a vector
   a_int_vector: assert property (@(posedge clk) disable iff (reset)
      $past(rx_cause || tx_cause) && (rx_cause || tx_cause)
      |-> interrupt && (vector != 8'h00))
      else $error("dl11_regs: interrupt without vector");

endmodule

`default_nettype wire

// ==== logic/baud_gen.sv ====
// ----------------------------------------
// baud tick generator
// 16x sample tick and 1x bit tick from clk
// ----------------------------------------
`default_nettype none

`include "dl11_cfg.svh"

module baud_gen
(
   input  wire  clk,
   input  wire  reset,
   output logic rx_tick,
   output logic tx_tick
);

   localparam int DIV_W = $clog2(`DL11_TICK_DIV);
   localparam int OS_W  = $clog2(`DL11_OVERSAMPLE);
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`DL11_TICK_DIV - 1);
   localparam logic [OS_W-1:0]  OS_LAST  = OS_W'(`DL11_OVERSAMPLE - 1);

   logic [DIV_W-1:0] div_cnt;
   logic [OS_W-1:0]  os_cnt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         os_cnt  <= '0;
         rx_tick <= 1'b0;
         tx_tick <= 1'b0;
      end
      else
      begin
         rx_tick <= (div_cnt == DIV_LAST);
         // bit tick lands on every 16th sample tick
         tx_tick <= (div_cnt == DIV_LAST) && (os_cnt == OS_LAST);
         div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
         if (div_cnt == DIV_LAST)
            os_cnt <= (os_cnt == OS_LAST) ? '0 : os_cnt + 1'b1;
      end
   end

   a_tick_align: assert property (@(posedge clk) disable iff (reset)
      tx_tick |-> rx_tick)
      else $error("baud_gen: bit tick off the sample grid");

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// ----------------------------------------
// serial transmitter, 8N1
// start, 8 data bits LSB first, one stop
// ----------------------------------------
`default_nettype none

module uart_tx
(
   input  wire               clk,
   input  wire               reset,
   input  wire               tx_tick,
   input  wire               ld_tx_data,
   input  serial_pkg::char_t tx_data,
   output logic              tx_out,
   output logic              tx_empty
);

   serial_pkg::tx_state_e state;
   serial_pkg::char_t     data_reg;
   logic [2:0]            bit_cnt;
   logic                  load;

   // take a character only when idle and nothing is pending
   assign load = ld_tx_data && tx_empty && (state == serial_pkg::TX_IDLE);

   always_ff @(posedge clk)
   begin
      if (load)
         data_reg <= tx_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= serial_pkg::TX_IDLE;
         tx_out   <= 1'b1;
         tx_empty <= 1'b1;
         bit_cnt  <= '0;
      end
      else
      begin
         case (state)
            serial_pkg::TX_IDLE:
               if (load)
                  tx_empty <= 1'b0;
               else if (!tx_empty && tx_tick)
               begin
                  // start bit begins on the bit grid
                  tx_out <= 1'b0;
                  state  <= serial_pkg::TX_START;
               end
            serial_pkg::TX_START:
               if (tx_tick)
               begin
                  tx_out  <= data_reg[0];
                  bit_cnt <= '0;
                  state   <= serial_pkg::TX_DATA;
               end
            serial_pkg::TX_DATA:
               if (tx_tick)
               begin
                  if (bit_cnt == 3'd7)
                  begin
                     tx_out <= 1'b1;
                     state  <= serial_pkg::TX_STOP;
                  end
                  else
                  begin
                     tx_out  <= data_reg[bit_cnt + 3'd1];
                     bit_cnt <= bit_cnt + 3'd1;
                  end
               end
            serial_pkg::TX_STOP:
               if (tx_tick)
               begin
                  // stop bit has lasted one full bit
                  tx_empty <= 1'b1;
                  state    <= serial_pkg::TX_IDLE;
               end
            default: state <= serial_pkg::TX_IDLE;
         endcase
      end
   end

   a_idle_mark: assert property (@(posedge clk) disable iff (reset)
      (state == serial_pkg::TX_IDLE) |-> tx_out)
      else $error("uart_tx: line not marking while idle");

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
// ----------------------------------------
// serial receiver, 8N1, 16x oversampled
// holds one character until unloaded
// ----------------------------------------
`default_nettype none

`include "dl11_cfg.svh"

module uart_rx
(
   input  wire               clk,
   input  wire               reset,
   input  wire               rx_tick,
   input  wire               rx_in,
   input  wire               uld_rx_data,
   output serial_pkg::char_t rx_data,
   output logic              rx_empty
);

   localparam int CNT_W = $clog2(`DL11_OVERSAMPLE);
   localparam logic [CNT_W-1:0] MID_TICK  = CNT_W'(`DL11_OVERSAMPLE / 2 - 1);
   localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(`DL11_OVERSAMPLE - 1);

   serial_pkg::rx_state_e state;
   serial_pkg::char_t     shreg;
   logic [CNT_W-1:0]      tick_cnt;
   logic [2:0]            bit_cnt;
   logic                  rx_meta;
   logic                  rx_sync;
   logic                  rx_prev;
   logic                  bit_due;
   logic                  sample_bit;
   logic                  frame_ok;

   // two-flop synchronizer plus one flop for edge detect
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end
      else
      begin
         rx_meta <= rx_in;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   assign bit_due    = rx_tick && (tick_cnt == LAST_TICK);
   assign sample_bit = bit_due && (state == serial_pkg::RX_DATA);
   assign frame_ok   = bit_due && (state == serial_pkg::RX_STOP) && rx_sync;

   always_ff @(posedge clk)
   begin
      if (sample_bit)
         shreg <= {rx_sync, shreg[7:1]};
      if (frame_ok)
         rx_data <= shreg;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= serial_pkg::RX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         rx_empty <= 1'b1;
      end
      else
      begin
         if (uld_rx_data && !rx_empty)
            rx_empty <= 1'b1;
         // a new frame overrides the unload
         if (frame_ok)
            rx_empty <= 1'b0;

         if (rx_tick && state != serial_pkg::RX_IDLE)
            tick_cnt <= tick_cnt + 1'b1;

         case (state)
            serial_pkg::RX_IDLE:
               if (rx_prev && !rx_sync)
               begin
                  tick_cnt <= '0;
                  state    <= serial_pkg::RX_START;
               end
            serial_pkg::RX_START:
               if (rx_tick && tick_cnt == MID_TICK)
               begin
                  // still low at mid start bit, otherwise a glitch
                  tick_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= rx_sync ? serial_pkg::RX_IDLE : serial_pkg::RX_DATA;
               end
            serial_pkg::RX_DATA:
               if (bit_due)
               begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7)
                     state <= serial_pkg::RX_STOP;
               end
            serial_pkg::RX_STOP:
               if (bit_due)
                  state <= serial_pkg::RX_IDLE;
            default: state <= serial_pkg::RX_IDLE;
         endcase
      end
   end

   a_empty_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(rx_empty) |-> $past(uld_rx_data) || $past(reset))
      else $error("uart_rx: character lost without unload");

endmodule

`default_nettype wire

// ==== logic/dl11_top.sv ====
// ----------------------------------------
// DL11 console serial line unit
// ----------------------------------------
`default_nettype none

module dl11_top
(
   input  wire                      clk,
   input  wire                      reset,
   input  iopage_pkg::iopage_addr_t iopage_addr,
   input  iopage_pkg::iopage_data_t data_in,
   input  wire                      iopage_rd,
   input  wire                      iopage_wr,
   // byte lane select, the registers always take the whole word
   input  wire                      iopage_byte_op,
   output iopage_pkg::iopage_data_t data_out,
   output logic                     decode,
   output logic                     interrupt,
   output logic [7:0]               vector,
   input  wire                      rs232_rx,
   output logic                     rs232_tx
);

   logic              rx_tick;
   logic              tx_tick;
   logic              ld_tx_data;
   logic              tx_empty;
   logic              uld_rx_data;
   logic              rx_empty;
   serial_pkg::char_t tx_data;
   serial_pkg::char_t rx_data;

   dl11_regs regs_i
   (
      .clk         (clk),
      .reset       (reset),
      .iopage_addr (iopage_addr),
      .data_in     (data_in),
      .iopage_rd   (iopage_rd),
      .iopage_wr   (iopage_wr),
      .data_out    (data_out),
      .decode      (decode),
      .interrupt   (interrupt),
      .vector      (vector),
      .ld_tx_data  (ld_tx_data),
      .tx_data     (tx_data),
      .uld_rx_data (uld_rx_data),
      .tx_empty    (tx_empty),
      .rx_empty    (rx_empty),
      .rx_data     (rx_data)
   );

   baud_gen baud_i
   (
      .clk     (clk),
      .reset   (reset),
      .rx_tick (rx_tick),
      .tx_tick (tx_tick)
   );

   uart_tx tx_i
   (
      .clk        (clk),
      .reset      (reset),
      .tx_tick    (tx_tick),
      .ld_tx_data (ld_tx_data),
      .tx_data    (tx_data),
      .tx_out     (rs232_tx),
      .tx_empty   (tx_empty)
   );

   uart_rx rx_i
   (
      .clk         (clk),
      .reset       (reset),
      .rx_tick     (rx_tick),
      .rx_in       (rs232_rx),
      .uld_rx_data (uld_rx_data),
      .rx_data     (rx_data),
      .rx_empty    (rx_empty)
   );

endmodule

`default_nettype wire

// ==== sim/dl11_tb.sv ====
// ----------------------------------------
// DL11 console line testbench
// bus register access, serial line model
// ----------------------------------------
`default_nettype none

`include "dl11_cfg.svh"

module dl11_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int BIT_CLKS    = `DL11_TICK_DIV * `DL11_OVERSAMPLE;
   localparam int START_LIMIT = 4 * BIT_CLKS;
   localparam int DONE_LIMIT  = 500;
   localparam int RX_LIMIT    = 40;

   logic                     clk = 1'b0;
   logic                     reset;
   iopage_pkg::iopage_addr_t iopage_addr;
   iopage_pkg::iopage_data_t data_in;
   logic                     iopage_rd;
   logic                     iopage_wr;
   logic                     iopage_byte_op;
   iopage_pkg::iopage_data_t data_out;
   logic                     decode;
   logic                     interrupt;
   logic [7:0]               vector;
   logic                     rs232_rx;
   logic                     rs232_tx;

   int                       check_errors = 0;
   int                       prop_errors = 0;
   int                       timeout_errors = 0;
   logic [31:0]              lcg_state = 32'h7995;
   iopage_pkg::iopage_data_t rd_val;
   serial_pkg::char_t        ch;
   serial_pkg::char_t        got_ch;
   logic                     got_stop;
   int                       k;

   dl11_top dut_i
   (
      .clk            (clk),
      .reset          (reset),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .data_out       (data_out),
      .decode         (decode),
      .interrupt      (interrupt),
      .vector         (vector),
      .rs232_rx       (rs232_rx),
      .rs232_tx       (rs232_tx)
   );

   always #10 clk = ~clk;

   function automatic serial_pkg::char_t random_char();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];
   endfunction

   function automatic logic is_reg_addr(input iopage_pkg::iopage_addr_t a);
      return (a == `DL11_RCSR_ADDR) || (a == `DL11_RBUF_ADDR) ||
             (a == `DL11_XCSR_ADDR) || (a == `DL11_XBUF_ADDR);
   endfunction

   // decode is high for the four register offsets and nothing else
   a_decode: assert property (@(posedge clk) decode == is_reg_addr(iopage_addr))
      else
      begin
         $display("[FAIL] decode exp=%h got=%h",
                  is_reg_addr($sampled(iopage_addr)), $sampled(decode));
         prop_errors++;
      end

   a_reset_line: assert property (@(posedge clk) reset |=> rs232_tx)
      else
      begin
         $display("[FAIL] rs232_tx exp=1 got=%h", $sampled(rs232_tx));
         prop_errors++;
      end

   a_reset_int: assert property (@(posedge clk) reset |=> !interrupt)
      else
      begin
         $display("[FAIL] interrupt exp=0 got=%h", $sampled(interrupt));
         prop_errors++;
      end

   // interrupt is one cycle behind a nonzero vector
   a_int_follows: assert property (@(posedge clk) disable iff (reset)
      interrupt == $past(vector != 8'h00))
      else
      begin
         $display("[FAIL] interrupt exp=%h got=%h",
                  !$sampled(interrupt), $sampled(interrupt));
         prop_errors++;
      end

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] got);
      assert (got === exp)
      else
      begin
         $display("[FAIL] %s exp=%h got=%h", name, exp, got);
         check_errors++;
      end
   endtask

   task automatic write_reg(input iopage_pkg::iopage_addr_t addr,
                            input iopage_pkg::iopage_data_t value);
      @(posedge clk);
      iopage_addr <= addr;
      data_in     <= value;
      iopage_wr   <= 1'b1;
      @(posedge clk);
      iopage_wr <= 1'b0;
   endtask

   // data_out is sampled at the falling edge
   task automatic read_reg(input iopage_pkg::iopage_addr_t addr,
                           output iopage_pkg::iopage_data_t value);
      @(posedge clk);
      iopage_addr <= addr;
      iopage_rd   <= 1'b1;
      @(negedge clk);
      value = data_out;
      @(posedge clk);
      iopage_rd <= 1'b0;
   endtask

   task automatic wait_done(input iopage_pkg::iopage_addr_t addr, input string name,
                            input int limit);
      iopage_pkg::iopage_data_t v;
      int                       n;
      v = '0;
      n = 0;
      while (!v[`DL11_CSR_DONE_BIT] && n < limit)
      begin
         read_reg(addr, v);
         n++;
      end
      if (!v[`DL11_CSR_DONE_BIT])
      begin
         $display("timeout: %s done bit was never set", name);
         timeout_errors++;
      end
   endtask

   // line model drives one frame on rs232_rx at 64 clk per bit
   task automatic send_frame(input serial_pkg::char_t c, input logic stop);
      int i;
      @(posedge clk);
      rs232_rx <= 1'b0;
      for (i = 0; i < 8; i++)
      begin
         repeat (BIT_CLKS) @(posedge clk);
         rs232_rx <= c[i];
      end
      repeat (BIT_CLKS) @(posedge clk);
      rs232_rx <= stop;
      repeat (BIT_CLKS) @(posedge clk);
      rs232_rx <= 1'b1;
   endtask

   // decode one frame from rs232_tx at mid-bit
   task automatic sample_frame(output serial_pkg::char_t c, output logic stop);
      int n;
      int i;
      c    = '0;
      stop = 1'b0;
      n    = 0;
      @(negedge clk);
      while (rs232_tx && n < START_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (rs232_tx)
      begin
         $display("timeout: no start bit appeared on rs232_tx");
         timeout_errors++;
      end
      else
      begin
         repeat (BIT_CLKS / 2) @(negedge clk);
         check_value("rs232_tx start", 16'h0000, {15'h0, rs232_tx});
         for (i = 0; i < 8; i++)
         begin
            repeat (BIT_CLKS) @(negedge clk);
            c[i] = rs232_tx;
         end
         repeat (BIT_CLKS) @(negedge clk);
         stop = rs232_tx;
      end
   endtask

   initial
   begin
      reset          <= 1'b1;
      iopage_addr    <= '0;
      data_in        <= '0;
      iopage_rd      <= 1'b0;
      iopage_wr      <= 1'b0;
      iopage_byte_op <= 1'b0;
      rs232_rx       <= 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);

      // state after reset
      read_reg(`DL11_RCSR_ADDR, rd_val);
      check_value("rcsr", 16'o000, rd_val);
      read_reg(`DL11_XCSR_ADDR, rd_val);
      check_value("xcsr", 16'o200, rd_val);
      read_reg(`DL11_XBUF_ADDR, rd_val);
      check_value("xbuf", 16'h0000, rd_val);
      @(negedge clk);
      check_value("interrupt", 16'h0000, {15'h0, interrupt});
      check_value("rs232_tx", 16'h0001, {15'h0, rs232_tx});
      read_reg(13'o17570, rd_val);
      check_value("data_out 17570", 16'h0000, rd_val);
      read_reg(13'o17556, rd_val);
      check_value("data_out 17556", 16'h0000, rd_val);
      read_reg(13'o17561, rd_val);
      check_value("data_out 17561", 16'h0000, rd_val);

      // transmit four characters back to back
      for (k = 0; k < 4; k++)
      begin
         ch = random_char();
         fork
            sample_frame(got_ch, got_stop);
            begin
               write_reg(`DL11_XBUF_ADDR, {8'h00, ch});
               read_reg(`DL11_XCSR_ADDR, rd_val);
               check_value("xcsr busy", 16'o000, rd_val);
               wait_done(`DL11_XCSR_ADDR, "xcsr", DONE_LIMIT);
            end
         join
         check_value("tx char", {8'h00, ch}, {8'h00, got_ch});
         check_value("tx stop", 16'h0001, {15'h0, got_stop});
      end

      // receive one character
      ch = random_char();
      send_frame(ch, 1'b1);
      wait_done(`DL11_RCSR_ADDR, "rcsr", RX_LIMIT);
      read_reg(`DL11_RBUF_ADDR, rd_val);
      check_value("rbuf", {8'h00, ch}, rd_val);
      read_reg(`DL11_RCSR_ADDR, rd_val);
      check_value("rcsr after read", 16'o000, rd_val);

      // transmit interrupt follows IE one cycle later
      write_reg(`DL11_XCSR_ADDR, 16'o100);
      @(negedge clk);
      check_value("vector", {8'h00, `DL11_TX_VECTOR}, {8'h00, vector});
      check_value("interrupt", 16'h0000, {15'h0, interrupt});
      @(negedge clk);
      check_value("interrupt", 16'h0001, {15'h0, interrupt});
      write_reg(`DL11_XCSR_ADDR, 16'o000);
      @(negedge clk);
      check_value("interrupt", 16'h0001, {15'h0, interrupt});
      @(negedge clk);
      check_value("interrupt", 16'h0000, {15'h0, interrupt});

      // receive wins over transmit
      write_reg(`DL11_RCSR_ADDR, 16'o100);
      write_reg(`DL11_XCSR_ADDR, 16'o100);
      ch = random_char();
      send_frame(ch, 1'b1);
      wait_done(`DL11_RCSR_ADDR, "rcsr", RX_LIMIT);
      @(negedge clk);
      check_value("vector", {8'h00, `DL11_RX_VECTOR}, {8'h00, vector});
      check_value("interrupt", 16'h0001, {15'h0, interrupt});
      read_reg(`DL11_RBUF_ADDR, rd_val);
      check_value("rbuf", {8'h00, ch}, rd_val);
      @(negedge clk);
      check_value("vector", {8'h00, `DL11_TX_VECTOR}, {8'h00, vector});
      write_reg(`DL11_RCSR_ADDR, 16'o000);
      write_reg(`DL11_XCSR_ADDR, 16'o000);

      // stop bit held low so the frame is dropped
      send_frame(random_char(), 1'b0);
      repeat (2 * BIT_CLKS) @(posedge clk);
      read_reg(`DL11_RCSR_ADDR, rd_val);
      check_value("rcsr framing", 16'o000, rd_val);

      $display("errors: checks=%0d assertions=%0d timeouts=%0d",
               check_errors, prop_errors, timeout_errors);
      if (check_errors == 0 && prop_errors == 0 && timeout_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/iopage_pkg.sv
logic/serial_pkg.sv
logic/dl11_regs.sv
logic/baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/dl11_top.sv
sim/dl11_tb.sv

// ==== Makefile ====
# Verilator build and run of the DL11 testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module dl11_tb \
		-Mdir obj_dir -o dl11_sim
	./obj_dir/dl11_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
